//--- design/opl_env_pkg.sv
// operator envelope definitions
package opl_env_pkg;

    localparam int ENV_WIDTH = 9;
    localparam int RATE_WIDTH = 4;
    localparam int TL_WIDTH = 6;
    localparam int KSL_WIDTH = 2;
    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int AM_VAL_WIDTH = 5;
    localparam int STEP_WIDTH = 3;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int KSL_ADD_WIDTH = 8;

    typedef logic [ENV_WIDTH-1:0] env_t;       // 0 loudest, 511 silent
    typedef logic [RATE_WIDTH-1:0] rate_t;     // ar, dr, sl, rr
    typedef logic [TL_WIDTH-1:0] tl_t;
    typedef logic [KSL_WIDTH-1:0] ksl_t;
    typedef logic [FNUM_WIDTH-1:0] fnum_t;
    typedef logic [BLOCK_WIDTH-1:0] block_t;   // octave
    typedef logic [AM_VAL_WIDTH-1:0] am_val_t;
    typedef logic [STEP_WIDTH-1:0] step_t;     // envelope steps per sample
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // register map
    localparam reg_addr_t ADDR_AR_DR = 3'd0;     // ar 7:4, dr 3:0
    localparam reg_addr_t ADDR_SL_RR = 3'd1;     // sl 7:4, rr 3:0
    localparam reg_addr_t ADDR_KSL_TL = 3'd2;    // ksl 7:6, tl 5:0
    localparam reg_addr_t ADDR_FLAGS = 3'd3;     // am 7, egt 5, ksr 4, mult 3:0
    localparam reg_addr_t ADDR_FNUM_LO = 3'd4;   // fnum 7:0
    localparam reg_addr_t ADDR_KEY_BLOCK = 3'd5; // key 5, block 4:2, fnum 9:8
    localparam reg_addr_t ADDR_GLOBAL = 3'd6;    // dam 7, nts 6

    typedef struct packed {
        rate_t  ar;
        rate_t  dr;
        rate_t  sl;
        rate_t  rr;
        tl_t    tl;
        ksl_t   ksl;
        logic   ksr;   // key scale rate
        logic   egt;   // sustain hold
        logic   am;    // tremolo enable
        fnum_t  fnum;
        block_t block;
    } op_cfg_t;

endpackage

//--- design/operator_regs.sv
// operator register block
module operator_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  opl_env_pkg::reg_addr_t wr_addr,
    input  logic [7:0]            wr_data,
    output opl_env_pkg::op_cfg_t  cfg,
    output logic                  dam,
    output logic                  nts,
    output logic                  key_on_pulse,
    output logic                  key_off_pulse
);
    import opl_env_pkg::*;

    logic key_q;      // last written key bit
    logic key_write;
    logic key_new;

    assign key_write = wr_en && (wr_addr == ADDR_KEY_BLOCK);
    assign key_new = wr_data[5];

    // edge detect on the key bit, pulse lands the cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            key_q <= 1'b0;
            key_on_pulse <= 1'b0;
            key_off_pulse <= 1'b0;
        end else begin
            key_on_pulse <= key_write && key_new && !key_q;
            key_off_pulse <= key_write && !key_new && key_q;
            if (key_write) begin
                key_q <= key_new;
            end
        end
    end

    // setting fields
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
            dam <= 1'b0;
            nts <= 1'b0;
        end else if (wr_en) begin
            case (wr_addr)
                ADDR_AR_DR: begin
                    cfg.ar <= wr_data[7:4];
                    cfg.dr <= wr_data[3:0];
                end
                ADDR_SL_RR: begin
                    cfg.sl <= wr_data[7:4];
                    cfg.rr <= wr_data[3:0];
                end
                ADDR_KSL_TL: begin
                    cfg.ksl <= wr_data[7:6];
                    cfg.tl <= wr_data[5:0];
                end
                ADDR_FLAGS: begin
                    cfg.am <= wr_data[7];
                    cfg.egt <= wr_data[5];
                    cfg.ksr <= wr_data[4]; // mult bits feed phase only, dropped here
                end
                ADDR_FNUM_LO: begin
                    cfg.fnum[7:0] <= wr_data;
                end
                ADDR_KEY_BLOCK: begin
                    cfg.block <= wr_data[4:2];
                    cfg.fnum[9:8] <= wr_data[1:0];
                end
                ADDR_GLOBAL: begin
                    dam <= wr_data[7];
                    nts <= wr_data[6];
                end
                default: begin
                end
            endcase
        end
    end

    // at most one key edge per write
    a_key_pulse_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(key_on_pulse && key_off_pulse)
    ) else $error("key on and key off pulses high together");

endmodule

//--- design/env_rate_counter.sv
// envelope rate counter
module env_rate_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_clk_en,
    input  opl_env_pkg::rate_t  requested_rate,
    input  logic               ksr,
    input  logic               nts,
    input  opl_env_pkg::fnum_t  fnum,
    input  opl_env_pkg::block_t block,
    output opl_env_pkg::step_t  rate_counter_overflow
);
    import opl_env_pkg::*;

    localparam int ACC_WIDTH = 15;
    localparam int SUM_WIDTH = ACC_WIDTH + 4;
    localparam int MAX_RATE = 60;

    logic [3:0]           ks_offset_full; // block*2 + split bit
    logic [3:0]           ks_offset;
    logic [6:0]           rate_sum;
    logic [5:0]           effective_rate;
    logic [ACC_WIDTH-1:0] acc;
    logic [SUM_WIDTH-1:0] increment;
    logic [SUM_WIDTH-1:0] sum;
    logic [3:0]           wraps;

    always_comb begin
        ks_offset_full = {block, nts ? fnum[8] : fnum[9]};
        ks_offset = ksr ? ks_offset_full : (ks_offset_full >> 2);
        rate_sum = {1'b0, requested_rate, 2'b00} + {3'b000, ks_offset};
        if (requested_rate == '0) begin
            effective_rate = '0;
        end else if (rate_sum > 7'(MAX_RATE)) begin
            effective_rate = 6'(MAX_RATE);
        end else begin
            effective_rate = rate_sum[5:0];
        end
        // (4 + rate mod 4) << rate / 4
        increment = SUM_WIDTH'({1'b1, effective_rate[1:0]}) << effective_rate[5:2];
        sum = SUM_WIDTH'(acc) + increment;
        wraps = sum[SUM_WIDTH-1:ACC_WIDTH];
    end

    assign rate_counter_overflow = (wraps > 4'd7) ? step_t'(7) : wraps[STEP_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (sample_clk_en) begin
            acc <= sum[ACC_WIDTH-1:0]; // keep the fraction
        end
    end

    a_rate_capped: assert property (
        @(posedge clk) disable iff (rst)
        effective_rate <= 6'(MAX_RATE)
    ) else $error("effective rate above 60");

endmodule

//--- design/ksl_add_rom.sv
// key scale level table
module ksl_add_rom (
    input  opl_env_pkg::fnum_t                        fnum,
    input  opl_env_pkg::block_t                       block,
    input  opl_env_pkg::ksl_t                         ksl,
    output logic [opl_env_pkg::KSL_ADD_WIDTH-1:0]     ksl_add
);
    logic [6:0] table_val;  // standard 16-entry curve
    logic [5:0] penalty;    // 8 per octave below the top
    logic [6:0] base;
    logic [6:0] shifted;
    logic [8:0] scaled;

    always_comb begin
        case (fnum[9:6])
            4'd0: table_val = 7'd0;
            4'd1: table_val = 7'd32;
            4'd2: table_val = 7'd40;
            4'd3: table_val = 7'd45;
            4'd4: table_val = 7'd48;
            4'd5: table_val = 7'd51;
            4'd6: table_val = 7'd53;
            4'd7: table_val = 7'd55;
            4'd8: table_val = 7'd56;
            4'd9: table_val = 7'd58;
            4'd10: table_val = 7'd59;
            4'd11: table_val = 7'd60;
            4'd12: table_val = 7'd61;
            4'd13: table_val = 7'd62;
            4'd14: table_val = 7'd63;
            default: table_val = 7'd64;
        endcase
    end

    always_comb begin
        penalty = {~block, 3'b000}; // 8 * (7 - block)
        base = (table_val > {1'b0, penalty}) ? table_val - {1'b0, penalty} : 7'd0;

        case (ksl)
            2'd0: shifted = 7'd0;
            2'd1: shifted = base >> 1;
            2'd2: shifted = base >> 2;
            default: shifted = base;
        endcase

        scaled = {shifted, 2'b00}; // into env units
    end

    // only the top entry at block 7 and ksl 3 reaches 256, held at 255
    assign ksl_add = (scaled > 9'd255) ? 8'hff : scaled[7:0];

endmodule

//--- design/tremolo.sv
// tremolo triangle generator
module tremolo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_clk_en,
    input  logic                 dam,
    output opl_env_pkg::am_val_t am_val
);
    import opl_env_pkg::*;

    localparam int CNT_WIDTH = 13;
    localparam int DEEP_MULT = 27;    // peak 26
    localparam int SHALLOW_MULT = 7;  // peak 6

    logic [CNT_WIDTH-1:0] cnt;
    logic [4:0]           tri_val;
    logic [9:0]           scaled;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (sample_clk_en) begin
            cnt <= cnt + 1'b1; // free running, wraps
        end
    end

    // fold the top bits into an up/down ramp
    always_comb begin
        if (cnt[CNT_WIDTH-1]) begin
            tri_val = ~cnt[CNT_WIDTH-2 -: 5];
        end else begin
            tri_val = cnt[CNT_WIDTH-2 -: 5];
        end

        if (dam) begin
            scaled = 10'(tri_val) * 10'(DEEP_MULT);
        end else begin
            scaled = 10'(tri_val) * 10'(SHALLOW_MULT);
        end
    end

    assign am_val = am_val_t'(scaled >> 5);

endmodule

//--- design/envelope_generator.sv
// ADSR envelope generator
module envelope_generator #(
    parameter opl_env_pkg::env_t SILENCE = 9'd511
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_clk_en,
    input  opl_env_pkg::op_cfg_t cfg,
    input  logic                 dam,
    input  logic                 nts,
    input  logic                 key_on_pulse,
    input  logic                 key_off_pulse,
    output opl_env_pkg::env_t    env
);
    import opl_env_pkg::*;

    localparam int SUM_WIDTH = ENV_WIDTH + 2;

    typedef enum logic [1:0] {
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } state_t;

    state_t                   state;
    state_t                   next_state;
    env_t                     env_int;        // raw envelope before level terms
    rate_t                    requested_rate;
    step_t                    rate_counter_overflow;
    logic [KSL_ADD_WIDTH-1:0] ksl_add;
    am_val_t                  am_val;
    logic [ENV_WIDTH+2:0]     attack_prod;
    env_t                     attack_step;
    logic [ENV_WIDTH:0]       decay_sum;
    logic [SUM_WIDTH-1:0]     env_tmp;

    always_comb begin
        case (state)
            ATTACK:  next_state = (env_int == '0) ? DECAY : ATTACK;
            DECAY:   next_state = ((env_int >> 4) >= ENV_WIDTH'(cfg.sl)) ? SUSTAIN : DECAY;
            SUSTAIN: next_state = cfg.egt ? SUSTAIN : RELEASE;
            default: next_state = RELEASE;
        endcase
    end

    always_comb begin
        case (state)
            ATTACK:  requested_rate = cfg.ar;
            DECAY:   requested_rate = cfg.dr;
            SUSTAIN: requested_rate = '0; // hold level
            default: requested_rate = cfg.rr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RELEASE;
        end else if (key_on_pulse) begin
            state <= ATTACK;
        end else if (key_off_pulse) begin
            state <= RELEASE;
        end else if (sample_clk_en) begin
            state <= next_state;
        end
    end

    env_rate_counter u_rate_counter (
        .clk                   (clk),
        .rst                   (rst),
        .sample_clk_en         (sample_clk_en),
        .requested_rate        (requested_rate),
        .ksr                   (cfg.ksr),
        .nts                   (nts),
        .fnum                  (cfg.fnum),
        .block                 (cfg.block),
        .rate_counter_overflow (rate_counter_overflow)
    );

    // exponential attack, linear decay and release
    assign attack_prod = (ENV_WIDTH+3)'(env_int) * (ENV_WIDTH+3)'(rate_counter_overflow);
    assign attack_step = attack_prod[ENV_WIDTH+2:3] + 1'b1;
    assign decay_sum = {1'b0, env_int} + (ENV_WIDTH+1)'(rate_counter_overflow);

    always_ff @(posedge clk) begin
        if (rst) begin
            env_int <= SILENCE;
        end else if (sample_clk_en) begin
            if (state == ATTACK && rate_counter_overflow != '0 && env_int != '0) begin
                env_int <= env_int - attack_step;
            end else if (state == DECAY || state == RELEASE) begin
                env_int <= (decay_sum > SILENCE) ? SILENCE : decay_sum[ENV_WIDTH-1:0];
            end
        end
    end

    ksl_add_rom u_ksl_add_rom (
        .fnum    (cfg.fnum),
        .block   (cfg.block),
        .ksl     (cfg.ksl),
        .ksl_add (ksl_add)
    );

    tremolo u_tremolo (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en),
        .dam           (dam),
        .am_val        (am_val)
    );

    assign env_tmp = SUM_WIDTH'(env_int) + SUM_WIDTH'({cfg.tl, 2'b00}) + SUM_WIDTH'(ksl_add)
                   + (cfg.am ? SUM_WIDTH'(am_val) : SUM_WIDTH'(0));

    always_ff @(posedge clk) begin
        if (rst) begin
            env <= SILENCE;
        end else begin
            env <= (env_tmp > SILENCE) ? SILENCE : env_tmp[ENV_WIDTH-1:0]; // clamp
        end
    end

    a_env_int_bound: assert property (
        @(posedge clk) disable iff (rst)
        env_int <= SILENCE
    ) else $error("env_int beyond silence");

endmodule

//--- design/env_top.sv
// operator envelope top level
module env_top #(
    parameter opl_env_pkg::env_t SILENCE = 9'd511
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sample_clk_en,  // one cycle per sample
    input  logic                   wr_en,
    input  opl_env_pkg::reg_addr_t wr_addr,
    input  logic [7:0]             wr_data,
    output opl_env_pkg::env_t      env
);
    import opl_env_pkg::*;

    op_cfg_t cfg;
    logic    dam;
    logic    nts;
    logic    key_on_pulse;
    logic    key_off_pulse;

    // host side settings
    operator_regs u_operator_regs (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .cfg           (cfg),
        .dam           (dam),
        .nts           (nts),
        .key_on_pulse  (key_on_pulse),
        .key_off_pulse (key_off_pulse)
    );

    envelope_generator #(
        .SILENCE (SILENCE)
    ) u_envelope_generator (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en),
        .cfg           (cfg),
        .dam           (dam),
        .nts           (nts),
        .key_on_pulse  (key_on_pulse),
        .key_off_pulse (key_off_pulse),
        .env           (env)
    );

endmodule

//--- sim/env_model.svh
// envelope reference model
`ifndef ENV_MODEL_SVH
`define ENV_MODEL_SVH

localparam int S_ATTACK = 0;
localparam int S_DECAY = 1;
localparam int S_SUSTAIN = 2;
localparam int S_RELEASE = 3;
localparam int M_SILENCE = 511;

opl_env_pkg::op_cfg_t m_cfg;
logic                 m_dam;
logic                 m_nts;
logic                 m_key_q;
logic                 m_on;
logic                 m_off;
int                   m_state;
int                   m_env_int;
int                   m_env;
int                   m_acc;       // 15-bit accumulator
int                   m_cnt;       // 13-bit tremolo counter

function automatic int eff_rate(input int rate);
    int off;
    int r;
    if (rate == 0) return 0;
    off = int'(m_cfg.block) * 2 + int'(m_nts ? m_cfg.fnum[8] : m_cfg.fnum[9]);
    if (!m_cfg.ksr) off = off / 4;
    r = rate * 4 + off;
    return (r > 60) ? 60 : r;
endfunction

function automatic int ksl_value();
    int tbl[16];
    int base;
    int v;
    tbl = '{0, 32, 40, 45, 48, 51, 53, 55, 56, 58, 59, 60, 61, 62, 63, 64};
    base = tbl[int'(m_cfg.fnum[9:6])] - 8 * (7 - int'(m_cfg.block));
    if (base < 0) base = 0;
    case (int'(m_cfg.ksl))
        0: v = 0;
        1: v = base / 2;
        2: v = base / 4;
        default: v = base;
    endcase
    v = v * 4;
    return (v > 255) ? 255 : v;
endfunction

function automatic int am_value();
    int tri_v;
    int pos;
    pos = (m_cnt / 128) % 32;
    tri_v = (m_cnt >= 4096) ? 31 - pos : pos;   // fold into a triangle
    return m_dam ? tri_v * 27 / 32 : tri_v * 7 / 32;
endfunction

task automatic model_reset();
    m_cfg = '0;
    m_dam = 1'b0;
    m_nts = 1'b0;
    m_key_q = 1'b0;
    m_on = 1'b0;
    m_off = 1'b0;
    m_state = S_RELEASE;
    m_env_int = M_SILENCE;
    m_env = M_SILENCE;
    m_acc = 0;
    m_cnt = 0;
endtask

// one clock edge, every update taken from the values before the edge
task automatic model_step(input logic we, input opl_env_pkg::reg_addr_t a,
                          input logic [7:0] d, input logic se);
    int rate;
    int eff;
    int sum;
    int ov;
    int total;
    int nxt;
    logic key_wr;
    case (m_state)
        S_ATTACK: rate = int'(m_cfg.ar);
        S_DECAY: rate = int'(m_cfg.dr);
        S_SUSTAIN: rate = 0;
        default: rate = int'(m_cfg.rr);
    endcase
    eff = eff_rate(rate);
    sum = m_acc + ((4 + eff % 4) << (eff / 4));
    ov = sum / 32768;
    if (ov > 7) ov = 7;
    total = m_env_int + 4 * int'(m_cfg.tl) + ksl_value() + (m_cfg.am ? am_value() : 0);
    case (m_state)
        S_ATTACK: nxt = (m_env_int == 0) ? S_DECAY : S_ATTACK;
        S_DECAY: nxt = (m_env_int / 16 >= int'(m_cfg.sl)) ? S_SUSTAIN : S_DECAY;
        S_SUSTAIN: nxt = m_cfg.egt ? S_SUSTAIN : S_RELEASE;
        default: nxt = S_RELEASE;
    endcase
    m_env = (total > M_SILENCE) ? M_SILENCE : total;
    if (se) begin
        if (m_state == S_ATTACK && ov != 0 && m_env_int != 0) begin
            m_env_int = m_env_int - ((m_env_int * ov) / 8 + 1);
        end else if (m_state == S_DECAY || m_state == S_RELEASE) begin
            m_env_int = (m_env_int + ov > M_SILENCE) ? M_SILENCE : m_env_int + ov;
        end
        m_acc = sum % 32768;
        m_cnt = (m_cnt + 1) % 8192;
    end
    if (m_on) m_state = S_ATTACK;
    else if (m_off) m_state = S_RELEASE;
    else if (se) m_state = nxt;
    key_wr = we && (a == opl_env_pkg::ADDR_KEY_BLOCK);
    m_on = key_wr && d[5] && !m_key_q;
    m_off = key_wr && !d[5] && m_key_q;
    if (key_wr) m_key_q = d[5];
    if (we) begin
        case (a)
            opl_env_pkg::ADDR_AR_DR: {m_cfg.ar, m_cfg.dr} = d;
            opl_env_pkg::ADDR_SL_RR: {m_cfg.sl, m_cfg.rr} = d;
            opl_env_pkg::ADDR_KSL_TL: {m_cfg.ksl, m_cfg.tl} = d;
            opl_env_pkg::ADDR_FLAGS: begin
                m_cfg.am = d[7];
                m_cfg.egt = d[5];
                m_cfg.ksr = d[4];
            end
            opl_env_pkg::ADDR_FNUM_LO: m_cfg.fnum[7:0] = d;
            opl_env_pkg::ADDR_KEY_BLOCK: {m_cfg.block, m_cfg.fnum[9:8]} = d[4:0];
            opl_env_pkg::ADDR_GLOBAL: {m_dam, m_nts} = d[7:6];
            default: begin
            end
        endcase
    end
endtask

`endif

//--- sim/tb_env.sv
// envelope testbench
module tb_env;
    import opl_env_pkg::*;

    logic      clk;
    logic      rst;
    logic      sample_clk_en;
    logic      wr_en;
    reg_addr_t wr_addr;
    logic [7:0] wr_data;
    env_t      env;

    logic [15:0] lfsr = 16'd39902;
    int          gap;
    logic [2:0]  cur_block;   // kept for key rewrites
    logic [1:0]  cur_fnum_hi;

    `include "env_model.svh"

    env_top #(.SILENCE(9'd511)) u_env_top (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .env           (env)
    );

    always #20 clk = ~clk;

    initial begin
        #40000000;
        $display("run exceeded its time limit");
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_env(input env_t got, input env_t exp);
        if (got !== exp) begin
            $display("error env got %h expected %h", got, exp);
            $display("Simulation failed");
            $fatal(1, "env mismatch");
        end
    endtask

    // one clock: drive, let the edge pass, step the model, compare
    task automatic cycle(input logic we, input reg_addr_t a, input logic [7:0] d);
        wr_en = we;
        wr_addr = a;
        wr_data = d;
        sample_clk_en = (gap == 0);
        if (gap == 0) gap = int'(rand_bits(2));   // 1 to 4 cycles apart
        else gap = gap - 1;
        @(posedge clk);
        model_step(we, a, d, sample_clk_en);
        #1;
        check_env(env, env_t'(m_env));
        #1;
    endtask

    task automatic write_reg(input reg_addr_t a, input logic [7:0] d);
        cycle(1'b1, a, d);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) cycle(1'b0, ADDR_AR_DR, 8'h00);
    endtask

    task automatic write_key(input logic key);
        write_reg(ADDR_KEY_BLOCK, {2'b00, key, cur_block, cur_fnum_hi});
    endtask

    task automatic wait_state(input int target, input int limit);
        int n;
        n = 0;
        while (m_state != target) begin
            if (n >= limit) begin
                $display("envelope did not reach the expected state in time");
                $display("Simulation failed");
                $fatal(1, "timeout");
            end
            cycle(1'b0, ADDR_AR_DR, 8'h00);
            n++;
        end
    endtask

    task automatic wait_silent(input int limit);
        int n;
        n = 0;
        while (m_env_int != M_SILENCE || m_state != S_RELEASE) begin
            if (n >= limit) begin
                $display("envelope did not return to silence in time");
                $display("Simulation failed");
                $fatal(1, "timeout");
            end
            cycle(1'b0, ADDR_AR_DR, 8'h00);
            n++;
        end
    endtask

    // fast rates 12..15 keep the run short
    task automatic random_voice(input logic egt, input logic am, input logic [5:0] tl);
        logic [3:0] sl;
        sl = 4'(rand_bits(4));
        write_reg(ADDR_AR_DR, {2'b11, 2'(rand_bits(2)), 2'b11, 2'(rand_bits(2))});
        write_reg(ADDR_SL_RR, {sl, 2'b11, 2'(rand_bits(2))});
        write_reg(ADDR_KSL_TL, {2'(rand_bits(2)), tl});
        write_reg(ADDR_FLAGS, {am, 1'b0, egt, 1'(rand_bits(1)), 4'(rand_bits(4))});
        write_reg(ADDR_FNUM_LO, 8'(rand_bits(8)));
        cur_block = 3'(rand_bits(3));
        cur_fnum_hi = 2'(rand_bits(2));
        write_reg(ADDR_GLOBAL, {2'(rand_bits(2)), 6'd0});
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        sample_clk_en = 1'b0;
        wr_en = 1'b0;
        wr_addr = ADDR_AR_DR;
        wr_data = 8'h00;
        gap = 0;
        cur_block = '0;
        cur_fnum_hi = '0;
        model_reset();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_env(env, env_t'(M_SILENCE));

        // no key-on, levels alone keep silence
        random_voice(1'b1, 1'b1, 6'(rand_bits(6)));
        idle(60);
        check_env(env, env_t'(M_SILENCE));

        // attack, decay, sustain hold
        for (int k = 0; k < 4; k++) begin
            random_voice(1'b1, 1'b0, 6'(rand_bits(6)));
            write_key(1'b1);
            wait_state(S_SUSTAIN, 60000);
            idle(100);
            write_key(1'b0);
            wait_silent(60000);
        end

        // egt clear runs straight to release
        random_voice(1'b0, 1'b0, 6'(rand_bits(6)));
        write_key(1'b1);
        wait_state(S_RELEASE, 60000);
        wait_silent(60000);

        // key-off mid envelope, same-key rewrites
        for (int k = 0; k < 4; k++) begin
            random_voice(1'b1, 1'b0, 6'(rand_bits(6)));
            write_key(1'b1);
            idle(int'(rand_bits(6)) + 5);
            write_key(1'b1);
            idle(10);
            write_key(1'b0);
            write_key(1'b0);
            wait_silent(60000);
        end

        // tremolo with dam toggled and high tl
        for (int k = 0; k < 4; k++) begin
            random_voice(1'b1, 1'b1, (k < 2) ? 6'd63 : 6'(rand_bits(6)));
            write_reg(ADDR_GLOBAL, {k[0], 1'(rand_bits(1)), 6'd0});
            write_key(1'b1);
            wait_state(S_SUSTAIN, 60000);
            idle(9000);
            write_key(1'b0);
            wait_silent(60000);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- tb.f
design/opl_env_pkg.sv
design/operator_regs.sv
design/env_rate_counter.sv
design/ksl_add_rom.sv
design/tremolo.sv
design/envelope_generator.sv
design/env_top.sv
+incdir+sim
sim/tb_env.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f tb.f --top-module tb_env -o tb_env_sim
./obj_dir/tb_env_sim
